// File: common/icache_defines.svh
/* instruction cache widths */

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch address
`define ICACHE_ADDR_W   32
`define ICACHE_INSN_W   32

// address split: tag | index | word | byte
`define ICACHE_INDEX_W  6
`define ICACHE_SETS     64
`define ICACHE_TAG_W    23

// one line is one memory beat
`define ICACHE_LINE_W   64

// saturating age per way
`define ICACHE_AGE_W    3

`endif

// File: common/icache_pkg.sv
/* instruction cache types */

`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

    // stored tag with its valid bit
    typedef struct packed {
        logic                       valid;
        logic [`ICACHE_TAG_W-1:0]   tag;
    } tag_entry_t;

    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic [`ICACHE_INDEX_W-1:0] index;
        logic                       word;
        logic [1:0]                 byte_off;
    } fetch_fields_t;

    // same fetch word, raw or split into fields
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0]  raw;
        fetch_fields_t              fields;
    } fetch_addr_u;

    // single-beat line read
    typedef struct packed {
        logic                       rd;
        logic [`ICACHE_ADDR_W-1:0]  addr;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        COMPARE,
        HIT,
        REFILL
    } ic_state_e;

endpackage

`default_nettype wire

// File: icache/icache_tag_ram.sv
/* icache tag store, one way */

`timescale 1ns/100ps
`default_nettype none

`include "icache_defines.svh"

module icache_tag_ram (
    input  wire logic                          clk,
    input  wire logic                          i_rst_n,
    input  wire logic [`ICACHE_INDEX_W-1:0]    i_index,
    input  wire logic                          i_we,
    input  wire logic [`ICACHE_TAG_W-1:0]      i_tag,
    output icache_pkg::tag_entry_t             o_entry
);

    logic [`ICACHE_TAG_W-1:0]  tag_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]   valid_q;

    // tag array itself, no reset
    always_ff @(posedge clk) begin
        if (i_we) begin
            tag_mem[i_index] <= i_tag;
        end
    end

    // valid bits and the registered read port
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= '0;
            o_entry <= '0;
        end else begin
            if (i_we) begin
                valid_q[i_index] <= 1'b1;
            end
            o_entry.valid <= valid_q[i_index];
            o_entry.tag   <= tag_mem[i_index];
        end
    end

endmodule

`default_nettype wire

// File: icache/icache_data_ram.sv
/* icache line store, one way */

`timescale 1ns/100ps
`default_nettype none

`include "icache_defines.svh"

module icache_data_ram (
    input  wire logic                          clk,
    input  wire logic [`ICACHE_INDEX_W-1:0]    i_index,
    input  wire logic                          i_we,
    input  wire logic [`ICACHE_LINE_W-1:0]     i_line,
    output logic [`ICACHE_LINE_W-1:0]          o_line
);

    logic [`ICACHE_LINE_W-1:0] line_mem [`ICACHE_SETS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            line_mem[i_index] <= i_line;
        end
    end

    // read is one cycle behind the index
    always_ff @(posedge clk) begin
        o_line <= line_mem[i_index];
    end

endmodule

`default_nettype wire

// File: icache/icache_age.sv
/* icache age counters and victim choice */

`timescale 1ns/100ps
`default_nettype none

`include "icache_defines.svh"

module icache_age (
    input  wire logic                          clk,
    input  wire logic                          i_rst_n,
    input  wire logic                          i_accept,
    input  wire logic [`ICACHE_INDEX_W-1:0]    i_index,
    input  wire logic                          i_touch0,
    input  wire logic                          i_touch1,
    input  wire logic                          i_valid0,
    input  wire logic                          i_valid1,
    output logic                               o_victim
);

    logic [`ICACHE_AGE_W-1:0] age0_q [`ICACHE_SETS];
    logic [`ICACHE_AGE_W-1:0] age1_q [`ICACHE_SETS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // counter update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // every accept ages all sets, a touch clears one entry
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                age0_q[s] <= '0;
                age1_q[s] <= '0;
            end
        end else begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                if (i_touch0 && (i_index == `ICACHE_INDEX_W'(s))) begin
                    age0_q[s] <= '0;
                end else if (i_accept && (age0_q[s] != '1)) begin
                    age0_q[s] <= age0_q[s] + 1'b1;
                end

                if (i_touch1 && (i_index == `ICACHE_INDEX_W'(s))) begin
                    age1_q[s] <= '0;
                end else if (i_accept && (age1_q[s] != '1)) begin
                    age1_q[s] <= age1_q[s] + 1'b1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // victim
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // invalid way first, then the older one, way 0 on a tie
    always_comb begin
        if (!i_valid0) begin
            o_victim = 1'b0;
        end else if (!i_valid1) begin
            o_victim = 1'b1;
        end else begin
            o_victim = (age0_q[i_index] >= age1_q[i_index]) ? 1'b0 : 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: icache/icache_ctrl.sv
/* icache lookup and refill control */

`timescale 1ns/100ps
`default_nettype none

`include "icache_defines.svh"

module icache_ctrl (
    input  wire logic                          clk,
    input  wire logic                          i_rst_n,
    // fetch side
    input  wire logic                          i_fetch_req,
    input  wire icache_pkg::fetch_addr_u       i_fetch_addr,
    input  wire logic                          i_stall,
    output logic                               o_fetch_valid,
    output logic [`ICACHE_INSN_W-1:0]          o_fetch_data,
    // memory side
    output icache_pkg::mem_req_t               o_mem_req,
    input  wire logic [`ICACHE_LINE_W-1:0]     i_mem_data,
    input  wire logic                          i_mem_valid,
    output logic                               o_mem_ack,
    // rams
    output logic [`ICACHE_INDEX_W-1:0]         o_index,
    output logic [`ICACHE_TAG_W-1:0]           o_tag,
    output logic                               o_we0,
    output logic                               o_we1,
    input  wire icache_pkg::tag_entry_t        i_entry0,
    input  wire icache_pkg::tag_entry_t        i_entry1,
    input  wire logic [`ICACHE_LINE_W-1:0]     i_line0,
    input  wire logic [`ICACHE_LINE_W-1:0]     i_line1,
    output logic [`ICACHE_LINE_W-1:0]          o_fill_line,
    // age block
    output logic                               o_accept,
    output logic                               o_touch0,
    output logic                               o_touch1,
    input  wire logic                          i_victim
);

    localparam int OFF_W = `ICACHE_ADDR_W - `ICACHE_TAG_W - `ICACHE_INDEX_W;

    icache_pkg::ic_state_e      state_q;
    icache_pkg::ic_state_e      state_d;
    logic                       hit0;
    logic                       hit1;
    logic [`ICACHE_LINE_W-1:0]  hit_line;
    logic                       hit_way_q;
    logic [`ICACHE_INSN_W-1:0]  word_q;

    assign o_index  = i_fetch_addr.fields.index;
    assign o_tag    = i_fetch_addr.fields.tag;

    // new request only once the last pulse is gone
    assign o_accept = (state_q == icache_pkg::IDLE) && i_fetch_req && !o_fetch_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE: begin
                if (o_accept) begin
                    state_d = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::LOOKUP: begin
                state_d = icache_pkg::COMPARE;
            end
            icache_pkg::COMPARE: begin
                state_d = (hit0 || hit1) ? icache_pkg::HIT : icache_pkg::REFILL;
            end
            icache_pkg::HIT: begin
                state_d = icache_pkg::IDLE;
            end
            icache_pkg::REFILL: begin
                // line lands this edge, look it up again
                if (i_mem_valid) begin
                    state_d = icache_pkg::LOOKUP;
                end
            end
            default: begin
                state_d = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= icache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare and word select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // ram outputs are valid in COMPARE
    assign hit0     = i_entry0.valid && (i_entry0.tag == i_fetch_addr.fields.tag);
    assign hit1     = i_entry1.valid && (i_entry1.tag == i_fetch_addr.fields.tag);
    assign hit_line = hit0 ? i_line0 : i_line1;

    always_ff @(posedge clk) begin
        if (state_q == icache_pkg::COMPARE) begin
            hit_way_q <= !hit0;
            if (i_fetch_addr.fields.word) begin
                word_q <= hit_line[`ICACHE_LINE_W-1 -: `ICACHE_INSN_W];
            end else begin
                word_q <= hit_line[`ICACHE_INSN_W-1:0];
            end
        end
    end

    // stall in HIT drops the answer
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_fetch_valid <= 1'b0;
        end else begin
            o_fetch_valid <= (state_q == icache_pkg::HIT) && !i_stall;
        end
    end

    assign o_fetch_data = word_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // refill
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign o_mem_ack      = (state_q == icache_pkg::REFILL) && i_mem_valid;
    assign o_mem_req.rd   = (state_q == icache_pkg::REFILL) && !i_mem_valid;
    assign o_mem_req.addr = {i_fetch_addr.raw[`ICACHE_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

    assign o_we0       = o_mem_ack && !i_victim;
    assign o_we1       = o_mem_ack && i_victim;
    assign o_fill_line = i_mem_data;

    // hit or fill makes the way youngest
    assign o_touch0 = ((state_q == icache_pkg::HIT) && !hit_way_q) || o_we0;
    assign o_touch1 = ((state_q == icache_pkg::HIT) && hit_way_q) || o_we1;

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
/* two-way instruction cache */

`timescale 1ns/100ps
`default_nettype none

`include "icache_defines.svh"

module icache_top (
    input  wire logic                          clk,
    input  wire logic                          i_rst_n,
    input  wire logic                          i_fetch_req,
    input  wire logic [`ICACHE_ADDR_W-1:0]     i_fetch_addr,
    input  wire logic                          i_stall,
    output logic                               o_fetch_valid,
    output logic [`ICACHE_INSN_W-1:0]          o_fetch_data,
    output icache_pkg::mem_req_t               o_mem_req,
    input  wire logic [`ICACHE_LINE_W-1:0]     i_mem_data,
    input  wire logic                          i_mem_valid,
    output logic                               o_mem_ack
);

    logic [`ICACHE_INDEX_W-1:0]  index;
    logic [`ICACHE_TAG_W-1:0]    tag;
    logic                        we0;
    logic                        we1;
    icache_pkg::tag_entry_t      entry0;
    icache_pkg::tag_entry_t      entry1;
    logic [`ICACHE_LINE_W-1:0]   line0;
    logic [`ICACHE_LINE_W-1:0]   line1;
    logic [`ICACHE_LINE_W-1:0]   fill_line;
    logic                        accept;
    logic                        touch0;
    logic                        touch1;
    logic                        victim;

    icache_ctrl icache_ctrl_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_fetch_req   (i_fetch_req),
        .i_fetch_addr  (i_fetch_addr),
        .i_stall       (i_stall),
        .o_fetch_valid (o_fetch_valid),
        .o_fetch_data  (o_fetch_data),
        .o_mem_req     (o_mem_req),
        .i_mem_data    (i_mem_data),
        .i_mem_valid   (i_mem_valid),
        .o_mem_ack     (o_mem_ack),
        .o_index       (index),
        .o_tag         (tag),
        .o_we0         (we0),
        .o_we1         (we1),
        .i_entry0      (entry0),
        .i_entry1      (entry1),
        .i_line0       (line0),
        .i_line1       (line1),
        .o_fill_line   (fill_line),
        .o_accept      (accept),
        .o_touch0      (touch0),
        .o_touch1      (touch1),
        .i_victim      (victim)
    );

    // way 0
    icache_tag_ram tag_ram0_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_index (index),
        .i_we    (we0),
        .i_tag   (tag),
        .o_entry (entry0)
    );

    icache_data_ram data_ram0_inst (
        .clk     (clk),
        .i_index (index),
        .i_we    (we0),
        .i_line  (fill_line),
        .o_line  (line0)
    );

    // way 1
    icache_tag_ram tag_ram1_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_index (index),
        .i_we    (we1),
        .i_tag   (tag),
        .o_entry (entry1)
    );

    icache_data_ram data_ram1_inst (
        .clk     (clk),
        .i_index (index),
        .i_we    (we1),
        .i_line  (fill_line),
        .o_line  (line1)
    );

    icache_age icache_age_inst (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_accept (accept),
        .i_index  (index),
        .i_touch0 (touch0),
        .i_touch1 (touch1),
        .i_valid0 (entry0.valid),
        .i_valid1 (entry1.valid),
        .o_victim (victim)
    );

endmodule

`default_nettype wire

// File: dv/tb_clkgen.sv
/* testbench clock and reset */

`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic o_rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // reset held for 4 cycles
    initial begin
        o_rst_n = 1'b0;
        repeat (4) @(posedge clk);
        o_rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/icache_assert.sv
/* icache protocol assertions */

`timescale 1ns/100ps
`default_nettype none

module icache_assert (
    input wire logic                 clk,
    input wire logic                 i_rst_n,
    input wire logic                 i_fetch_valid,
    input wire icache_pkg::mem_req_t i_mem_req,
    input wire logic                 i_mem_valid,
    input wire logic                 i_mem_ack
);

    // ack exactly with a response to a held read
    ack_with_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_mem_ack || i_mem_valid) |-> (i_mem_ack && i_mem_valid && $past(i_mem_req.rd)))
        else $error("o_mem_ack not matched with i_mem_valid after a held read");

    // answer is a single-cycle pulse
    fetch_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_fetch_valid |=> !i_fetch_valid)
        else $error("o_fetch_valid held longer than one cycle");

    // read level and address hold until the response
    read_held: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_mem_req.rd |=> ((i_mem_req.rd || i_mem_valid) && $stable(i_mem_req.addr)))
        else $error("memory read dropped or changed before the response");

endmodule

bind icache_top icache_assert icache_assert_inst (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_fetch_valid (o_fetch_valid),
    .i_mem_req     (o_mem_req),
    .i_mem_valid   (i_mem_valid),
    .i_mem_ack     (o_mem_ack)
);

`default_nettype wire

// File: dv/tb_icache.sv
/* icache testbench */

`timescale 1ns/100ps
`default_nettype none

`include "icache_defines.svh"

module tb_icache;

    localparam int TIMEOUT = 200;

    logic                         clk;
    logic                         rst_n;
    logic                         fetch_req;
    logic [`ICACHE_ADDR_W-1:0]    fetch_addr;
    logic                         stall;
    logic                         fetch_valid;
    logic [`ICACHE_INSN_W-1:0]    fetch_data;
    icache_pkg::mem_req_t         mem_req;
    logic [`ICACHE_LINE_W-1:0]    mem_data;
    logic                         mem_valid;
    logic                         mem_ack;

    // reference cache state
    logic [`ICACHE_TAG_W-1:0]     m_tag   [2][`ICACHE_SETS];
    logic                         m_valid [2][`ICACHE_SETS];
    logic [`ICACHE_AGE_W-1:0]     m_age   [2][`ICACHE_SETS];

    logic [31:0]                  lcg_state;
    logic [`ICACHE_INSN_W-1:0]    exp_data;
    logic [`ICACHE_ADDR_W-1:0]    exp_line_addr;
    int                           mem_reads;
    int                           errors;
    int                           checks;

    tb_clkgen tb_clkgen_inst (
        .clk     (clk),
        .o_rst_n (rst_n)
    );

    icache_top icache_top_inst (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_fetch_req   (fetch_req),
        .i_fetch_addr  (fetch_addr),
        .i_stall       (stall),
        .o_fetch_valid (fetch_valid),
        .o_fetch_data  (fetch_data),
        .o_mem_req     (mem_req),
        .i_mem_data    (mem_data),
        .i_mem_valid   (mem_valid),
        .o_mem_ack     (mem_ack)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] make_addr(input int tg, input int idx, input logic word);
        return {23'(tg), 6'(idx), word, 2'b00};
    endfunction

    // memory content derived from the line address
    function automatic logic [63:0] line_of(input logic [31:0] a);
        logic [31:0] la;
        la = {a[31:3], 3'b000};
        return {la ^ 32'hc3a5_0f1e, ~la + 32'h1234_5678};
    endfunction

    function automatic logic [31:0] word_of(input logic [31:0] a);
        logic [63:0] ln;
        ln = line_of(a);
        return a[2] ? ln[63:32] : ln[31:0];
    endfunction

    // one accepted request ages all sets then hits or fills
    function automatic logic model_access(input logic [31:0] a);
        logic [5:0]  idx;
        logic [22:0] tg;
        logic        hit;
        logic        way;
        idx = a[8:3];
        tg  = a[31:9];
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                if (m_age[w][s] != 3'd7) begin
                    m_age[w][s] = m_age[w][s] + 3'd1;
                end
            end
        end
        hit = 1'b0;
        way = 1'b0;
        if (m_valid[0][idx] && m_tag[0][idx] == tg) begin
            hit = 1'b1;
        end else if (m_valid[1][idx] && m_tag[1][idx] == tg) begin
            hit = 1'b1;
            way = 1'b1;
        end
        if (!hit) begin
            if (!m_valid[0][idx]) begin
                way = 1'b0;
            end else if (!m_valid[1][idx]) begin
                way = 1'b1;
            end else begin
                way = (m_age[0][idx] >= m_age[1][idx]) ? 1'b0 : 1'b1;
            end
            m_tag[way][idx]   = tg;
            m_valid[way][idx] = 1'b1;
        end
        m_age[way][idx] = '0;
        return hit;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory model and compare process
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int delay;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req.rd) begin
                mem_reads++;
                checks++;
                assert (mem_req.addr == exp_line_addr)
                else begin
                    $display("Error: o_mem_req.addr got %h expected %h",
                             mem_req.addr, exp_line_addr);
                    errors++;
                end
                delay = 1 + int'(next_rand() % 6);
                repeat (delay) @(posedge clk);
                mem_valid <= 1'b1;
                mem_data  <= line_of(mem_req.addr);
                @(negedge clk);
                checks++;
                assert (mem_ack == 1'b1)
                else begin
                    $display("Error: o_mem_ack got %h expected %h", mem_ack, 1'b1);
                    errors++;
                end
                @(posedge clk);
                mem_valid <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && fetch_valid) begin
            checks++;
            assert (fetch_data == exp_data)
            else begin
                $display("Error: o_fetch_data got %h expected %h", fetch_data, exp_data);
                errors++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // stall_rel > 0 holds i_stall until that cycle
    task automatic fetch(input logic [31:0] a, input int stall_rel);
        logic exp_hit;
        int   reads_before;
        int   cycles;
        logic got;
        exp_hit = model_access(a);
        if (stall_rel > 0) begin
            void'(model_access(a));
        end
        exp_data      = word_of(a);
        exp_line_addr = {a[31:3], 3'b000};
        reads_before  = mem_reads;
        @(posedge clk);
        fetch_req  <= 1'b1;
        fetch_addr <= a;
        stall      <= (stall_rel > 0);
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if (cycles == stall_rel) begin
                stall <= 1'b0;
            end
            @(negedge clk);
            got = fetch_valid;
        end
        @(posedge clk);
        fetch_req <= 1'b0;
        checks++;
        assert (got)
        else begin
            $display("no fetch response for address %h within %0d cycles", a, TIMEOUT);
            errors++;
        end
        assert ((mem_reads - reads_before) == (exp_hit ? 0 : 1))
        else begin
            $display("Error: memory reads for %h got %h expected %h",
                     a, mem_reads - reads_before, exp_hit ? 0 : 1);
            errors++;
        end
        if (exp_hit) begin
            assert (cycles == ((stall_rel > 0) ? 8 : 4))
            else begin
                $display("Error: hit latency for %h got %h expected %h",
                         a, cycles, (stall_rel > 0) ? 8 : 4);
                errors++;
            end
        end
    endtask

    initial begin
        int n;
        logic [31:0] r;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        stall      = 1'b0;
        mem_data   = '0;
        mem_valid  = 1'b0;
        lcg_state  = 32'h8e10_0155;
        mem_reads  = 0;
        errors     = 0;
        checks     = 0;
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                m_tag[w][s]   = '0;
                m_valid[w][s] = 1'b0;
                m_age[w][s]   = '0;
            end
        end
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        checks++;
        assert (rst_n === 1'b1)
        else begin
            $display("reset still asserted after %0d cycles", n);
            errors++;
        end

        // cold miss, then hits on both words
        fetch(make_addr(17, 3, 1'b0), 0);
        fetch(make_addr(17, 3, 1'b0), 0);
        fetch(make_addr(17, 3, 1'b1), 0);

        // three tags in one set
        fetch(make_addr(1, 5, 1'b0), 0);
        fetch(make_addr(2, 5, 1'b1), 0);
        fetch(make_addr(1, 5, 1'b1), 0);
        fetch(make_addr(3, 5, 1'b0), 0);
        fetch(make_addr(2, 5, 1'b0), 0);
        fetch(make_addr(1, 5, 1'b0), 0);
        fetch(make_addr(3, 5, 1'b1), 0);
        fetch(make_addr(2, 5, 1'b1), 0);

        // stalled hit is answered after release
        fetch(make_addr(17, 3, 1'b1), 6);
        fetch(make_addr(17, 3, 1'b0), 0);

        // random stream over four sets
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            fetch(make_addr(int'(r[10:8]) % 5, int'(r[17:16]), r[20]), 0);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: icache.f
+incdir+common
common/icache_pkg.sv
icache/icache_tag_ram.sv
icache/icache_data_ram.sv
icache/icache_age.sv
icache/icache_ctrl.sv
rtl/icache_top.sv
dv/tb_clkgen.sv
dv/icache_assert.sv
dv/tb_icache.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f icache.f --top-module tb_icache -o Vtb_icache

run: build
	@out="$$(./obj_dir/Vtb_icache)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only --timing -f icache.f --top-module tb_icache

clean:
	rm -rf obj_dir
